/* source/spi_defines.svh */
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

////////////////////
// frame geometry
////////////////////

`define SPI_CMD_WIDTH  12 // full frame, flag + addr + data
`define SPI_READ_WIDTH 8  // data bits returned by a read
`define SPI_ADDR_WIDTH 3  // register address field

////////////////////
// sclk timing
////////////////////

// clk cycles per sclk half period, one bit is twice this
`define SPI_HALF_DIV   4

`endif

/* source/spi_cmd_pkg.sv */
`include "spi_defines.svh"

package spi_cmd_pkg;

  ////////////////////
  // opcode
  ////////////////////

  // bit 11 of the command word
  typedef enum logic {
    SPI_OP_READ  = 1'b0,
    SPI_OP_WRITE = 1'b1
  } spi_op_e;

  ////////////////////
  // decoded frame
  ////////////////////

  typedef struct packed {
    spi_op_e                   op;         // latched by result stage
    logic [`SPI_CMD_WIDTH-1:0] shift_word; // mosi bits, msb sent first
  } spi_frame_t;

endpackage

/* source/spi_link_pkg.sv */
package spi_link_pkg;

  ////////////////////
  // bit engine FSM
  ////////////////////

  typedef enum logic [1:0] {
    ENG_IDLE  = 2'd0, // cs high, waiting for frame_start
    ENG_SETUP = 2'd1, // sclk low half, mosi settling
    ENG_SHIFT = 2'd2, // sclk high half
    ENG_HOLD  = 2'd3  // cs hold after last falling edge
  } eng_state_e;

  ////////////////////
  // engine to result
  ////////////////////

  typedef struct packed {
    logic sample;     // one per sclk rise
    logic miso_bit;   // value seen on that rise
    logic frame_done; // cs back high
  } bit_event_t;

endpackage

/* source/spi_cmd_decode.sv */
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_cmd_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`SPI_CMD_WIDTH-1:0] cmd_in,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  input  logic                      frame_done,
  output spi_cmd_pkg::spi_frame_t   frame,
  output logic                      frame_start
);

  localparam int HDR_WIDTH = 1 + `SPI_ADDR_WIDTH; // op flag plus address

  logic                 busy;
  logic                 accept;
  logic [HDR_WIDTH-1:0] header;
  spi_cmd_pkg::spi_op_e op_in;

  assign cmd_rdy = ~busy;
  assign accept  = cmd_vld & ~busy;        // anything while busy is dropped
  assign header  = cmd_in[`SPI_CMD_WIDTH-1 -: HDR_WIDTH];
  assign op_in   = spi_cmd_pkg::spi_op_e'(cmd_in[`SPI_CMD_WIDTH-1]);

  ////////////////////
  // busy level
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy        <= 1'b0;
      frame_start <= 1'b0;
    end
    else
    begin
      frame_start <= accept;               // one cycle after acceptance
      if (accept)
        busy <= 1'b1;
      else if (frame_done)
        busy <= 1'b0;
    end
  end

  // frame payload
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      frame.op <= op_in;
      if (op_in == spi_cmd_pkg::SPI_OP_WRITE)
        frame.shift_word <= cmd_in;
      else
        frame.shift_word <= {header, {`SPI_READ_WIDTH{1'b0}}}; // zeros in read phase
    end
  end

endmodule

/* source/spi_bit_engine.sv */
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_bit_engine (
  input  logic                     clk,
  input  logic                     rst_n,
  input  spi_cmd_pkg::spi_frame_t  frame,
  input  logic                     frame_start,
  output logic                     sclk,
  output logic                     cs,
  output logic                     mosi,
  input  logic                     miso,
  output spi_link_pkg::bit_event_t events
);

  localparam int               DIV_W    = (`SPI_HALF_DIV > 1) ? $clog2(`SPI_HALF_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_HALF_DIV - 1);
  localparam logic [3:0]       BIT_LAST = 4'(`SPI_CMD_WIDTH - 1);
  localparam int               MSB      = `SPI_CMD_WIDTH - 1;

  spi_link_pkg::eng_state_e  state;
  logic [DIV_W-1:0]          div_cnt;
  logic [3:0]                bit_cnt;
  logic [`SPI_CMD_WIDTH-1:0] shreg;
  logic                      half_done;
  logic                      load;
  logic                      advance;

  assign half_done = (div_cnt == DIV_LAST);
  assign load      = (state == spi_link_pkg::ENG_IDLE) & frame_start;
  // falling edge that moves on to another bit
  assign advance   = (state == spi_link_pkg::ENG_SHIFT) & half_done & (bit_cnt != BIT_LAST);

  ////////////////////
  // control FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= spi_link_pkg::ENG_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs      <= 1'b1;
      mosi    <= 1'b0;
      events  <= '0;
    end
    else
    begin
      events.sample     <= 1'b0;            // strobes
      events.frame_done <= 1'b0;
      case (state)
        spi_link_pkg::ENG_IDLE:
        begin
          if (load)
          begin
            cs      <= 1'b0;
            mosi    <= frame.shift_word[MSB]; // first bit with cs fall
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= spi_link_pkg::ENG_SETUP;
          end
        end
        spi_link_pkg::ENG_SETUP:
        begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done)
          begin
            sclk            <= 1'b1;        // rising edge
            events.sample   <= 1'b1;
            events.miso_bit <= miso;
            state           <= spi_link_pkg::ENG_SHIFT;
          end
        end
        spi_link_pkg::ENG_SHIFT:
        begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done)
          begin
            sclk <= 1'b0;                   // falling edge
            if (advance)
            begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= shreg[MSB-1];
              state   <= spi_link_pkg::ENG_SETUP;
            end
            else
              state <= spi_link_pkg::ENG_HOLD;
          end
        end
        spi_link_pkg::ENG_HOLD:
        begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done)
          begin
            cs                <= 1'b1;
            mosi              <= 1'b0;
            events.frame_done <= 1'b1;
            state             <= spi_link_pkg::ENG_IDLE;
          end
        end
        default: state <= spi_link_pkg::ENG_IDLE;
      endcase
    end
  end

  // outgoing word, msb is the bit on mosi
  always_ff @(posedge clk)
  begin
    if (load)
      shreg <= frame.shift_word;
    else if (advance)
      shreg <= shreg << 1;
  end

endmodule

/* source/spi_read_result.sv */
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_read_result (
  input  logic                       clk,
  input  logic                       rst_n,
  input  spi_cmd_pkg::spi_frame_t    frame,
  input  logic                       frame_start,
  input  spi_link_pkg::bit_event_t   events,
  output logic                       read_vld,
  output logic [`SPI_READ_WIDTH-1:0] read_data
);

  spi_cmd_pkg::spi_op_e       op;
  logic [`SPI_READ_WIDTH-1:0] rx_shreg;
  logic                       read_end;

  assign read_end = events.frame_done & (op == spi_cmd_pkg::SPI_OP_READ);

  ////////////////////
  // op and strobe
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      op       <= spi_cmd_pkg::SPI_OP_WRITE;
      read_vld <= 1'b0;
    end
    else
    begin
      if (frame_start)
        op <= frame.op;
      read_vld <= read_end;                 // writes never pulse
    end
  end

  // last 8 samples survive the 12 shifts
  always_ff @(posedge clk)
  begin
    if (events.sample)
      rx_shreg <= {rx_shreg[`SPI_READ_WIDTH-2:0], events.miso_bit};
    if (read_end)
      read_data <= rx_shreg;                // held until next read
  end

endmodule

/* source/spi_master.sv */
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_master (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`SPI_CMD_WIDTH-1:0]  cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  output logic                       sclk,
  output logic                       cs,
  output logic                       mosi,
  input  logic                       miso,
  output logic                       read_vld,
  output logic [`SPI_READ_WIDTH-1:0] read_data
);

  spi_cmd_pkg::spi_frame_t  frame;
  logic                     frame_start;
  spi_link_pkg::bit_event_t events;

  ////////////////////
  // decode
  ////////////////////

  spi_cmd_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .frame_done  (events.frame_done),
    .frame       (frame),
    .frame_start (frame_start)
  );

  ////////////////////
  // bus side
  ////////////////////

  spi_bit_engine u_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_start (frame_start),
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .miso        (miso),
    .events      (events)
  );

  spi_read_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_start (frame_start),
    .events      (events),
    .read_vld    (read_vld),
    .read_data   (read_data)
  );

endmodule

/* tests/spi_master_assertions.sv */
`timescale 1ns/100ps

module spi_master_assertions (
  input logic clk,
  input logic rst_n,
  input logic sclk,
  input logic cs,
  input logic mosi,
  input logic cmd_rdy,
  input logic read_vld
);

  int fail_cnt = 0; // read by the testbench

  ////////////////////
  // bus protocol
  ////////////////////

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
  else
  begin
    fail_cnt++;
    $error("sclk high while cs is high");
  end

  a_mosi_stable: assert property (@(posedge clk) disable iff (!rst_n) sclk |-> $stable(mosi))
  else
  begin
    fail_cnt++;
    $error("mosi changed while sclk is high");
  end

  // handshake side
  a_busy: assert property (@(posedge clk) disable iff (!rst_n) !cs |-> !cmd_rdy)
  else
  begin
    fail_cnt++;
    $error("cmd_rdy high during a frame");
  end

  a_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
  else
  begin
    fail_cnt++;
    $error("read_vld longer than one cycle");
  end

endmodule

/* tests/spi_master_tb.sv */
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_master_tb;

  localparam int CW      = `SPI_CMD_WIDTH;
  localparam int RW      = `SPI_READ_WIDTH;
  localparam int HDR_W   = CW - RW;          // flag plus address
  localparam int TIMEOUT = 2000;             // clk cycles per wait
  localparam int SEL_CS  = 0;
  localparam int SEL_RDY = 1;
  localparam int SEL_VLD = 2;

  logic          clk = 1'b0;
  logic          rst_n;
  logic [CW-1:0] cmd_in;
  logic          cmd_vld;
  logic          cmd_rdy;
  logic          sclk;
  logic          cs;
  logic          mosi;
  logic          miso;
  logic          read_vld;
  logic [RW-1:0] read_data;

  logic [RW-1:0] slave_resp;
  logic [CW-1:0] slave_rx;
  int            rise_cnt;
  int            window_cnt;
  int            vld_cnt;
  logic          sclk_q;
  logic          cs_q;
  int            checks;
  int            errors;
  int            err0;
  bit            timed_out;

  always #50 clk = ~clk;

  spi_master u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  bind spi_master spi_master_assertions u_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .cs       (cs),
    .mosi     (mosi),
    .cmd_rdy  (cmd_rdy),
    .read_vld (read_vld)
  );

  ////////////////////
  // slave model
  ////////////////////

  always @(negedge clk)
  begin
    if (cs_q && !cs)
    begin
      window_cnt++;
      rise_cnt = 0;
      slave_rx = '0;
    end
    if (!cs && sclk && !sclk_q)              // sclk rose since last look
    begin
      slave_rx = {slave_rx[CW-2:0], mosi};
      rise_cnt++;
    end
    if (!cs && !sclk)                         // after the fall, ahead of the next rise
      miso = (rise_cnt >= HDR_W && rise_cnt < CW) ? slave_resp[CW-1-rise_cnt] : 1'b0;
    if (read_vld)
      vld_cnt++;
    sclk_q = sclk;
    cs_q   = cs;
  end

  ////////////////////
  // checks
  ////////////////////

  function automatic spi_cmd_pkg::spi_frame_t expect_frame(input logic [CW-1:0] cmd);
    spi_cmd_pkg::spi_frame_t f;
    f.op = cmd[CW-1] ? spi_cmd_pkg::SPI_OP_WRITE : spi_cmd_pkg::SPI_OP_READ;
    if (f.op == spi_cmd_pkg::SPI_OP_WRITE)
      f.shift_word = cmd;
    else
      f.shift_word = {cmd[CW-1 -: HDR_W], {RW{1'b0}}}; // header then zeros
    return f;
  endfunction

  task automatic check_frame(input spi_cmd_pkg::spi_frame_t exp, input logic [CW-1:0] got,
                             input string what);
    checks++;
    if (got !== exp.shift_word)
    begin
      errors++;
      $display("Fail %0t: %s mosi word expected %h got %h", $time, what, exp.shift_word, got);
    end
  endtask

  task automatic check_read(input logic [RW-1:0] exp, input logic [RW-1:0] got,
                            input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %0t: %s read_data expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_count(input int exp, input int got, input string what);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("Fail %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_level(input logic exp, input logic got, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %0t: %s expected %b got %b", $time, what, exp, got);
    end
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      SEL_CS:  return cs;
      SEL_RDY: return cmd_rdy;
      default: return read_vld;
    endcase
  endfunction

  task automatic wait_level(input int sel, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (!timed_out && probe(sel) !== level)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
      begin
        $display("timed out waiting for %s", what);
        timed_out = 1'b1;
        errors++;
      end
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic send_cmd(input logic [CW-1:0] cmd);
    wait_level(SEL_RDY, 1'b1, "cmd_rdy");
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic do_frame(input logic [CW-1:0] cmd, input logic [RW-1:0] resp,
                          input string what);
    spi_cmd_pkg::spi_frame_t exp;
    int                      win0;
    int                      vld0;
    logic [RW-1:0]           data0;
    exp        = expect_frame(cmd);
    win0       = window_cnt;
    vld0       = vld_cnt;
    data0      = read_data;
    slave_resp = resp;
    send_cmd(cmd);
    wait_level(SEL_CS, 1'b0, "cs to fall");
    wait_level(SEL_CS, 1'b1, "cs to rise");
    if (exp.op == spi_cmd_pkg::SPI_OP_READ)
    begin
      wait_level(SEL_VLD, 1'b1, "read_vld");
      if (!timed_out)
        check_read(resp, read_data, what);
    end
    wait_level(SEL_RDY, 1'b1, "cmd_rdy to return");
    @(negedge clk);                           // let the slave counters settle
    if (timed_out)
      return;
    check_count(1, window_cnt - win0, {what, " cs windows"});
    check_count(CW, rise_cnt, {what, " sclk pulses"});
    check_frame(exp, slave_rx, what);
    if (exp.op == spi_cmd_pkg::SPI_OP_WRITE)
    begin
      check_count(0, vld_cnt - vld0, {what, " read_vld pulses"});
      check_read(data0, read_data, {what, " held"});
    end
    else
      check_count(1, vld_cnt - vld0, {what, " read_vld pulses"});
  endtask

  task automatic test_reset();
    check_level(1'b1, cmd_rdy, "cmd_rdy after reset");
    check_level(1'b1, cs, "cs after reset");
    check_level(1'b0, sclk, "sclk after reset");
    check_level(1'b0, mosi, "mosi after reset");
    check_level(1'b0, read_vld, "read_vld after reset");
  endtask

  task automatic test_frames(input int n, input logic write, input bit alternate);
    logic [CW-1:0] cmd;
    for (int i = 0; i < n && !timed_out; i++)
    begin
      cmd       = CW'($urandom);
      cmd[CW-1] = alternate ? i[0] : write;
      do_frame(cmd, RW'($urandom), cmd[CW-1] ? "write" : "read");
    end
  endtask

  task automatic test_busy();
    logic [CW-1:0] first;
    int            win0;
    int            vld0;
    first       = CW'($urandom);
    first[CW-1] = 1'b1;
    win0        = window_cnt;
    vld0        = vld_cnt;
    send_cmd(first);
    check_level(1'b0, cmd_rdy, "cmd_rdy after accept");
    wait_level(SEL_CS, 1'b0, "cs to fall");
    cmd_in  = ~first;                         // dropped, engine is busy
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    wait_level(SEL_CS, 1'b1, "cs to rise");
    wait_level(SEL_RDY, 1'b1, "cmd_rdy to return");
    @(negedge clk);
    if (timed_out)
      return;
    check_count(1, window_cnt - win0, "busy cs windows");
    check_count(0, vld_cnt - vld0, "busy read_vld pulses");
    check_frame(expect_frame(first), slave_rx, "busy first");
    do_frame({1'b0, (CW-1)'($urandom)}, RW'($urandom), "after busy");
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start)
      $display("%-8s ok", name);
    else
      $display("%-8s %0d errors", name, errors - err_start);
  endtask

  initial
  begin
    void'($urandom(89865));
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    miso       = 1'b0;
    slave_resp = '0;
    slave_rx   = '0;
    rise_cnt   = 0;
    window_cnt = 0;
    vld_cnt    = 0;
    sclk_q     = 1'b0;
    cs_q       = 1'b1;
    checks     = 0;
    errors     = 0;
    timed_out  = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    err0 = errors;
    test_reset();
    report_test("reset", err0);
    err0 = errors;
    test_frames(6, 1'b1, 1'b0);
    report_test("writes", err0);
    err0 = errors;
    test_frames(6, 1'b0, 1'b0);
    report_test("reads", err0);
    err0 = errors;
    test_busy();
    report_test("busy", err0);
    err0 = errors;
    test_frames(8, 1'b0, 1'b1);
    report_test("mixed", err0);

    errors += u_dut.u_assertions.fail_cnt;
    $display("%0d checks, %0d errors, %0d assertion failures",
             checks, errors, u_dut.u_assertions.fail_cnt);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* files.f */
+incdir+source
source/spi_cmd_pkg.sv
source/spi_link_pkg.sv
source/spi_cmd_decode.sv
source/spi_bit_engine.sv
source/spi_read_result.sv
source/spi_master.sv
tests/spi_master_assertions.sv
tests/spi_master_tb.sv

/* Bender.yml */
package:
  name: spi_master

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/spi_cmd_pkg.sv
      - source/spi_link_pkg.sv
      - source/spi_cmd_decode.sv
      - source/spi_bit_engine.sv
      - source/spi_read_result.sv
      - source/spi_master.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/spi_master_assertions.sv
      - tests/spi_master_tb.sv
